// ==== compile.f ====
+incdir+hdl
hdl/hazard_pkg.sv
hdl/fetch_buffer.sv
hdl/slot_decoder.sv
hdl/issue_select.sv
hdl/hazard_unit.sv
verification/hazard_assertions.sv
verification/hazard_unit_tb.sv

// ==== hdl/fetch_buffer.sv ====
`timescale 1ns/1ps
`include "hazard_config.svh"

module fetch_buffer
  import hazard_pkg::*;
(
  input  logic                    clock,
  input  logic                    reset,
  input  logic                    clear,
  input  logic                    ready,
  input  pc_t                     fetch_pc,
  input  logic [`FETCH_WIDTH-1:0] fetch_data,
  input  issue_t                  issue_count,
  output pc_t                     head_pc [`ISSUE_WIDTH],
  output instr_t                  head_instr [`ISSUE_WIDTH],
  output count_t                  occupancy,
  output logic                    stall
);

  localparam int ptr_width = $clog2(`HAZARD_DEPTH);

  pc_t                  pc_mem [`HAZARD_DEPTH];
  instr_t               instr_mem [`HAZARD_DEPTH];
  logic [ptr_width-1:0] wr_ptr;
  logic [ptr_width-1:0] wr_ptr_next;
  logic [ptr_width-1:0] rd_ptr;
  logic [ptr_width-1:0] rd_ptr_next;
  count_t               count;
  count_t               stored;
  count_t               next_count;
  logic                 accept;
  instr_t               word_lo;
  instr_t               word_hi;
  pc_t                  pc_hi;

  assign word_lo = fetch_data[`XLEN-1:0];
  assign word_hi = fetch_data[`FETCH_WIDTH-1:`XLEN];
  assign pc_hi = fetch_pc + pc_t'(4);
  assign wr_ptr_next = wr_ptr + 1'b1;
  assign rd_ptr_next = rd_ptr + 1'b1;

  assign accept = ready && !stall && !clear;

  // A clear hides the stored entries from the issue side in the same cycle
  assign stored = clear ? count_t'(0) : count;
  assign occupancy = stored + (accept ? count_t'(2) : count_t'(0));
  assign next_count = occupancy - count_t'(issue_count);

  // Stored entries come first, the arriving pair fills whatever slot is left
  always_comb begin
    head_pc[0] = '0;
    head_instr[0] = `NOP_INSTR;
    head_pc[1] = '0;
    head_instr[1] = `NOP_INSTR;
    if (stored != count_t'(0)) begin
      head_pc[0] = pc_mem[rd_ptr];
      head_instr[0] = instr_mem[rd_ptr];
    end else if (accept) begin
      head_pc[0] = fetch_pc;
      head_instr[0] = word_lo;
    end
    if (stored > count_t'(1)) begin
      head_pc[1] = pc_mem[rd_ptr_next];
      head_instr[1] = instr_mem[rd_ptr_next];
    end else if (accept && stored == count_t'(1)) begin
      head_pc[1] = fetch_pc;
      head_instr[1] = word_lo;
    end else if (accept) begin
      head_pc[1] = pc_hi;
      head_instr[1] = word_hi;
    end
  end

  always_ff @(posedge clock) begin
    if (accept) begin
      pc_mem[wr_ptr] <= fetch_pc;
      instr_mem[wr_ptr] <= word_lo;
      pc_mem[wr_ptr_next] <= pc_hi;
      instr_mem[wr_ptr_next] <= word_hi;
    end
  end

  always_ff @(posedge clock) begin
    if (!reset || clear) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
      stall <= 1'b0;
    end else begin
      if (accept) begin
        wr_ptr <= wr_ptr + ptr_width'(2);
      end
      rd_ptr <= rd_ptr + ptr_width'(issue_count);
      count <= next_count;
      stall <= next_count > count_t'(`STALL_LEVEL);
    end
  end

endmodule

// ==== hdl/hazard_config.svh ====
`ifndef HAZARD_CONFIG_SVH
`define HAZARD_CONFIG_SVH

// Buffer entries, one instruction word each
`define HAZARD_DEPTH 8

// Instruction and PC width
`define XLEN 32

// A fetched pair is two instruction words
`define FETCH_WIDTH 64

`define REG_ADDR_WIDTH 5

// Decode slots, and the most instructions issued in one cycle
`define ISSUE_WIDTH 2

// addi x0, x0, 0
`define NOP_INSTR 32'h00000013

// Fetch stalls while the occupancy is above this level
`define STALL_LEVEL (`HAZARD_DEPTH / 2)

`endif

// ==== hdl/hazard_pkg.sv ====
`include "hazard_config.svh"

package hazard_pkg;

  typedef logic [`XLEN-1:0] instr_t;

  typedef logic [`XLEN-1:0] pc_t;

  typedef logic [`REG_ADDR_WIDTH-1:0] reg_addr_t;

  // Must hold every value from empty to full
  typedef logic [$clog2(`HAZARD_DEPTH+1)-1:0] count_t;

  // Instructions leaving the buffer in one cycle, 0 to 2
  typedef logic [1:0] issue_t;

  // RV32I base opcodes, instr[6:0]
  typedef enum logic [6:0] {
    opcode_lui    = 7'b0110111,
    opcode_auipc  = 7'b0010111,
    opcode_jal    = 7'b1101111,
    opcode_jalr   = 7'b1100111,
    opcode_branch = 7'b1100011,
    opcode_load   = 7'b0000011,
    opcode_store  = 7'b0100011,
    opcode_op_imm = 7'b0010011,
    opcode_op     = 7'b0110011,
    opcode_fence  = 7'b0001111,
    opcode_system = 7'b1110011
  } opcode_e;

  // ALU funct3, shared by op and op-imm
  typedef enum logic [2:0] {
    funct_add  = 3'b000,
    funct_sll  = 3'b001,
    funct_slt  = 3'b010,
    funct_sltu = 3'b011,
    funct_xor  = 3'b100,
    funct_srl  = 3'b101,
    funct_or   = 3'b110,
    funct_and  = 3'b111
  } funct3_e;

endpackage

// ==== hdl/hazard_unit.sv ====
`timescale 1ns/1ps
`include "hazard_config.svh"

module hazard_unit
  import hazard_pkg::*;
(
  input  logic                    clock,
  input  logic                    reset,
  input  logic                    clear,
  input  logic                    ready,
  input  logic                    hold,
  input  pc_t                     fetch_pc,
  input  logic [`FETCH_WIDTH-1:0] fetch_data,
  output logic                    stall,
  output pc_t                     pc0,
  output instr_t                  instr0,
  output pc_t                     pc1,
  output instr_t                  instr1
);

  pc_t       head_pc [`ISSUE_WIDTH];
  instr_t    head_instr [`ISSUE_WIDTH];
  count_t    occupancy;
  issue_t    issue_count;
  logic      basic [`ISSUE_WIDTH];
  logic      complex [`ISSUE_WIDTH];
  logic      wren [`ISSUE_WIDTH];
  logic      rden1 [`ISSUE_WIDTH];
  logic      rden2 [`ISSUE_WIDTH];
  reg_addr_t waddr [`ISSUE_WIDTH];
  reg_addr_t raddr1 [`ISSUE_WIDTH];
  reg_addr_t raddr2 [`ISSUE_WIDTH];

  fetch_buffer fetch_buffer_inst (
    .clock       (clock),
    .reset       (reset),
    .clear       (clear),
    .ready       (ready),
    .fetch_pc    (fetch_pc),
    .fetch_data  (fetch_data),
    .issue_count (issue_count),
    .head_pc     (head_pc),
    .head_instr  (head_instr),
    .occupancy   (occupancy),
    .stall       (stall)
  );

  for (genvar i = 0; i < `ISSUE_WIDTH; i++) begin : g_slot
    slot_decoder slot_decoder_inst (
      .instr   (head_instr[i]),
      .basic   (basic[i]),
      .complex (complex[i]),
      .wren    (wren[i]),
      .rden1   (rden1[i]),
      .rden2   (rden2[i]),
      .waddr   (waddr[i]),
      .raddr1  (raddr1[i]),
      .raddr2  (raddr2[i])
    );
  end

  // Only the slot 0 write and the slot 1 reads matter for pairing
  issue_select issue_select_inst (
    .occupancy   (occupancy),
    .hold        (hold),
    .head_pc     (head_pc),
    .head_instr  (head_instr),
    .basic_0     (basic[0]),
    .complex_0   (complex[0]),
    .wren_0      (wren[0]),
    .waddr_0     (waddr[0]),
    .basic_1     (basic[1]),
    .rden1_1     (rden1[1]),
    .rden2_1     (rden2[1]),
    .raddr1_1    (raddr1[1]),
    .raddr2_1    (raddr2[1]),
    .issue_count (issue_count),
    .pc0         (pc0),
    .instr0      (instr0),
    .pc1         (pc1),
    .instr1      (instr1)
  );

endmodule

// ==== hdl/issue_select.sv ====
`timescale 1ns/1ps
`include "hazard_config.svh"

module issue_select
  import hazard_pkg::*;
(
  input  count_t    occupancy,
  input  logic      hold,
  input  pc_t       head_pc [`ISSUE_WIDTH],
  input  instr_t    head_instr [`ISSUE_WIDTH],
  input  logic      basic_0,
  input  logic      complex_0,
  input  logic      wren_0,
  input  reg_addr_t waddr_0,
  input  logic      basic_1,
  input  logic      rden1_1,
  input  logic      rden2_1,
  input  reg_addr_t raddr1_1,
  input  reg_addr_t raddr2_1,
  output issue_t    issue_count,
  output pc_t       pc0,
  output instr_t    instr0,
  output pc_t       pc1,
  output instr_t    instr1
);

  issue_t wanted;
  logic   raw_hazard;

  // Slot 1 reads what slot 0 is about to write
  assign raw_hazard = wren_0 && ((rden1_1 && raddr1_1 == waddr_0) ||
                                 (rden2_1 && raddr2_1 == waddr_0));

  // Slot 0 issues whatever its class, only slot 1 decides on pairing
  always_comb begin
    if (hold) begin
      wanted = 2'd0;
    end else if (basic_1) begin
      wanted = raw_hazard ? 2'd1 : 2'd2;
    end else begin
      wanted = 2'd1;
    end
  end

  // An empty slot decodes as a NOP, so the count still has to be capped
  assign issue_count = (occupancy < count_t'(wanted)) ? issue_t'(occupancy) : wanted;

  assign pc0 = (issue_count != 2'd0) ? head_pc[0] : '0;
  assign instr0 = (issue_count != 2'd0) ? head_instr[0] : `NOP_INSTR;
  assign pc1 = (issue_count == 2'd2) ? head_pc[1] : '0;
  assign instr1 = (issue_count == 2'd2) ? head_instr[1] : `NOP_INSTR;

endmodule

// ==== hdl/slot_decoder.sv ====
`timescale 1ns/1ps
`include "hazard_config.svh"

module slot_decoder
  import hazard_pkg::*;
(
  input  instr_t    instr,
  output logic      basic,
  output logic      complex,
  output logic      wren,
  output logic      rden1,
  output logic      rden2,
  output reg_addr_t waddr,
  output reg_addr_t raddr1,
  output reg_addr_t raddr2
);

  opcode_e    opcode;
  funct3_e    funct3;
  logic [6:0] funct7;
  logic       writes;
  logic       rd_nonzero;

  assign opcode = opcode_e'(instr[6:0]);
  assign funct3 = funct3_e'(instr[14:12]);
  assign funct7 = instr[31:25];

  assign waddr = instr[7 +: `REG_ADDR_WIDTH];
  assign raddr1 = instr[15 +: `REG_ADDR_WIDTH];
  assign raddr2 = instr[20 +: `REG_ADDR_WIDTH];

  assign rd_nonzero = |waddr;

  always_comb begin
    basic = 1'b0;
    writes = 1'b0;
    rden1 = 1'b0;
    rden2 = 1'b0;
    case (opcode)
      opcode_lui, opcode_auipc, opcode_jal: begin
        writes = 1'b1;
      end
      opcode_jalr, opcode_load: begin
        writes = 1'b1;
        rden1 = 1'b1;
      end
      opcode_branch, opcode_store: begin
        rden1 = 1'b1;
        rden2 = 1'b1;
      end
      opcode_op_imm: begin
        writes = 1'b1;
        rden1 = 1'b1;
        // For shifts the upper immediate bits select the variant
        case (funct3)
          funct_sll: basic = (funct7 == 7'b0000000);
          funct_srl: basic = (funct7 == 7'b0000000) || (funct7 == 7'b0100000);
          default: basic = 1'b1;
        endcase
      end
      opcode_op: begin
        writes = 1'b1;
        rden1 = 1'b1;
        rden2 = 1'b1;
        if (funct7 == 7'b0000000) begin
          basic = 1'b1;
        end else if (funct7 == 7'b0100000) begin
          basic = (funct3 == funct_add) || (funct3 == funct_srl);
        end
      end
      opcode_system: begin
        // CSR accesses only, the immediate forms read no register
        writes = !(instr[14:12] inside {3'd0, 3'd4});
        rden1 = instr[14:12] inside {3'd1, 3'd2, 3'd3};
      end
      default: begin
        // Fence and any opcode not listed here issue alone as complex
        writes = 1'b0;
      end
    endcase
  end

  // Nothing ever depends on a write to x0
  assign wren = writes && rd_nonzero;
  assign complex = !basic;

endmodule

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal -f compile.f --top-module hazard_unit_tb
./obj_dir/Vhazard_unit_tb | tee sim.log
if grep -qx "Simulation passed" sim.log; then
  exit 0
fi
echo "Testbench did not report success, see sim.log"
exit 1

// ==== verification/hazard_assertions.sv ====
`timescale 1ns/1ps
`include "hazard_config.svh"

module hazard_assertions (
  input logic        clock,
  input logic        reset,
  input logic        hold,
  input logic        stall,
  input logic [31:0] pc0,
  input logic [31:0] instr0,
  input logic [31:0] pc1
);

  // Fetch must be open again as soon as reset is released
  assert property (@(posedge clock) !reset |=> !stall)
    else $error("stall is high in the cycle after reset");

  assert property (@(posedge clock) disable iff (!reset) (pc1 != '0) |-> (pc0 != '0))
    else $error("slot 1 issued without slot 0");

  assert property (@(posedge clock) disable iff (!reset) hold |-> (instr0 == `NOP_INSTR))
    else $error("slot 0 issued while hold was high");

endmodule

bind hazard_unit hazard_assertions hazard_assertions_inst (
  .clock  (clock),
  .reset  (reset),
  .hold   (hold),
  .stall  (stall),
  .pc0    (pc0),
  .instr0 (instr0),
  .pc1    (pc1)
);

// ==== verification/hazard_cases.txt ====
// test clear ready hold fetch_pc data_lo data_hi | expected stall pc0 instr0 pc1 instr1
// data_lo is the instruction at fetch_pc, data_hi the one at fetch_pc + 4; test 0 ends the list
// Two independent basic instructions
1 0 1 0 00000100 003100B3 005241B3  0 00000100 003100B3 00000104 005241B3
1 0 0 0 00000000 00000000 00000000  0 00000000 00000013 00000000 00000013
// Read after write on x5, then a pair whose slot 0 writes x0
2 0 1 0 00000200 00708293 00228333  0 00000200 00708293 00000000 00000013
2 0 0 0 00000000 00000000 00000000  0 00000204 00228333 00000000 00000013
2 0 1 0 00000300 00208033 000003B3  0 00000300 00208033 00000304 000003B3
// Load in slot 1, mul in slot 1 through the bypass, then mul and sub together
3 0 1 0 00000400 003100B3 0004A403  0 00000400 003100B3 00000000 00000013
3 0 1 0 00000500 02C58533 40F706B3  0 00000404 0004A403 00000000 00000013
3 0 0 0 00000000 00000000 00000000  0 00000500 02C58533 00000504 40F706B3
// Hold fills the buffer until stall refuses the fourth pair, then drain
4 0 1 1 00000600 00100093 00200113  0 00000000 00000013 00000000 00000013
4 0 1 1 00000608 00300193 00400213  0 00000000 00000013 00000000 00000013
4 0 1 1 00000610 00500293 00600313  0 00000000 00000013 00000000 00000013
4 0 1 1 00000618 00700393 00800413  1 00000000 00000013 00000000 00000013
4 0 1 0 00000618 00700393 00800413  1 00000600 00100093 00000604 00200113
4 0 1 0 00000618 00700393 00800413  0 00000608 00300193 0000060C 00400213
4 0 0 0 00000000 00000000 00000000  0 00000610 00500293 00000614 00600313
4 0 0 0 00000000 00000000 00000000  0 00000618 00700393 0000061C 00800413
// Clear drops the held pair and refuses the one offered with it
5 0 1 1 00000700 00900493 00A00513  0 00000000 00000013 00000000 00000013
5 1 1 0 00000800 00B00593 00C00613  0 00000000 00000013 00000000 00000013
5 0 1 0 00000800 00B00593 00C00613  0 00000800 00B00593 00000804 00C00613
5 0 0 0 00000000 00000000 00000000  0 00000000 00000013 00000000 00000013
0 0 0 0 00000000 00000000 00000000  0 00000000 00000000 00000000 00000000

// ==== verification/hazard_unit_tb.sv ====
`timescale 1ns/1ps
`include "hazard_config.svh"

module hazard_unit_tb;

  localparam int fields = 12;
  localparam int max_cases = 64;

  logic        clock;
  logic        reset;
  logic        clear;
  logic        ready;
  logic        hold;
  logic [31:0] fetch_pc;
  logic [63:0] fetch_data;
  logic        stall;
  logic [31:0] pc0;
  logic [31:0] instr0;
  logic [31:0] pc1;
  logic [31:0] instr1;

  // Twelve words per cycle, laid out as the columns of the case file
  logic [31:0] case_mem [fields*max_cases];
  int          case_total;
  int          error_count;
  int          test_errors;
  int          lines_in_test;
  int          tests_passed;
  int          tests_failed;

  hazard_unit hazard_unit_inst (
    .clock      (clock),
    .reset      (reset),
    .clear      (clear),
    .ready      (ready),
    .hold       (hold),
    .fetch_pc   (fetch_pc),
    .fetch_data (fetch_data),
    .stall      (stall),
    .pc0        (pc0),
    .instr0     (instr0),
    .pc1        (pc1),
    .instr1     (instr1)
  );

  always #4 clock = ~clock;

  task automatic compare_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
    if (actual !== expected) begin
      $display("CHECK FAILED at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
      error_count++;
      test_errors++;
    end
  endtask

  task automatic report_test(input int test_id);
    if (test_errors == 0) begin
      $display("Test %0d passed over %0d cycles", test_id, lines_in_test);
      tests_passed++;
    end else begin
      $display("Test %0d failed with %0d wrong values", test_id, test_errors);
      tests_failed++;
    end
    test_errors = 0;
    lines_in_test = 0;
  endtask

  task automatic run_cases();
    int n;
    int base;
    int test_id;
    for (n = 0; n < case_total; n++) begin
      base = n * fields;
      test_id = case_mem[base];
      @(posedge clock);
      #1;
      clear = case_mem[base+1][0];
      ready = case_mem[base+2][0];
      hold = case_mem[base+3][0];
      fetch_pc = case_mem[base+4];
      fetch_data = {case_mem[base+6], case_mem[base+5]};
      // Sample just before the next rising edge
      #6;
      compare_value("stall", case_mem[base+7], {31'b0, stall});
      compare_value("pc0", case_mem[base+8], pc0);
      compare_value("instr0", case_mem[base+9], instr0);
      compare_value("pc1", case_mem[base+10], pc1);
      compare_value("instr1", case_mem[base+11], instr1);
      lines_in_test++;
      if (n == case_total - 1 || case_mem[base+fields] != case_mem[base]) begin
        report_test(test_id);
      end
    end
  endtask

  initial begin
    clock = 1'b0;
    reset = 1'b0;
    clear = 1'b0;
    ready = 1'b0;
    hold = 1'b0;
    fetch_pc = '0;
    fetch_data = {`NOP_INSTR, `NOP_INSTR};
    error_count = 0;
    test_errors = 0;
    lines_in_test = 0;
    tests_passed = 0;
    tests_failed = 0;
    case_total = 0;
    $readmemh("verification/hazard_cases.txt", case_mem);
    // A test number of zero marks the end of the cases
    while (case_total < max_cases && case_mem[case_total*fields] != 0) begin
      case_total++;
    end
    if (case_total == 0) begin
      $display("No cases could be read from verification/hazard_cases.txt");
      error_count++;
    end else begin
      repeat (10) @(posedge clock);
      #1;
      reset = 1'b1;
      run_cases();
    end
    $display("Tests passed: %0d, tests failed: %0d, wrong values: %0d",
             tests_passed, tests_failed, error_count);
    if (error_count == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  // Four clock periods per case plus the reset time is plenty of margin
  initial begin
    wait (case_total != 0);
    #(case_total * 8 * 4 + 10 * 8);
    $display("The run timed out before all %0d cases were applied", case_total);
    $display("Simulation failed");
    $finish;
  end

endmodule
